// File: common/periph_pkg.sv
`default_nettype none

package periph_pkg;

  // ====================
  // Bus widths
  // ====================

  localparam int unsigned DATA_W = 32;
  localparam int unsigned ADDR_W = 32;

  localparam int unsigned LED_W = 16;
  localparam int unsigned SW_W  = 16;

  // ====================
  // Address map
  // ====================

  localparam logic [ADDR_W-1:0] LED_BASE    = 32'h0000_1000;
  localparam logic [ADDR_W-1:0] SW_BASE     = 32'h0000_2000;
  localparam int unsigned       PERIPH_SPAN = 32'h100;

  // Offset bits inside one window
  localparam int unsigned OFFS_W = $clog2(PERIPH_SPAN);

  // Register offsets, shared by both peripherals
  localparam logic [ADDR_W-1:0] REG_VALUE   = 32'h00;
  localparam logic [ADDR_W-1:0] REG_MODE    = 32'h04;
  localparam logic [ADDR_W-1:0] REG_IRQ_EN  = 32'h08;
  localparam logic [ADDR_W-1:0] REG_CHANGED = 32'h0C;
  localparam logic [ADDR_W-1:0] REG_RESET   = 32'h24;

  // Cycles lit and then dark in blink mode
  localparam int unsigned BLINK_HALF_DEFAULT = 10_000_000;

  // Which device answers the current access
  typedef enum logic [1:0] {
    SEL_NONE,
    SEL_LED,
    SEL_SW
  } sel_e;

endpackage

`default_nettype wire

// File: common/periph_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

interface periph_bus_if;
  import periph_pkg::*;

  // One-cycle request, read data follows on the next edge
  logic              req;
  logic              we;
  logic [ADDR_W-1:0] addr;
  logic [DATA_W-1:0] wdata;
  logic [DATA_W-1:0] rdata;

  modport host (
    output req, we, addr, wdata,
    input  rdata
  );

  modport device (
    input  req, we, addr, wdata,
    output rdata
  );

endinterface

`default_nettype wire

// File: led_ctrl/led_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module led_ctrl #(
  parameter int unsigned BLINK_HALF = periph_pkg::BLINK_HALF_DEFAULT
) (
  input  logic                         clk_i,
  input  logic                         rst_i,

  periph_bus_if.device                 bus,

  output logic [periph_pkg::LED_W-1:0] led_o
);
  import periph_pkg::*;

  logic [LED_W-1:0] led_val;
  logic             led_mode;
  logic [31:0]      cntr;

  logic             wr;
  logic             rd;
  logic             soft_reset;
  logic             val_wr;
  logic             mode_wr;
  logic             cntr_wrap;

  // ====================
  // Write decode
  // ====================

  assign wr = bus.req & bus.we;
  assign rd = bus.req & ~bus.we;

  assign soft_reset = wr & (bus.addr == REG_RESET) & (bus.wdata == DATA_W'(1));

  // Value only accepted when it fits in the LED width
  assign val_wr = wr & (bus.addr == REG_VALUE) & (bus.wdata[DATA_W-1:LED_W] == '0);

  // Modes other than 0 and 1 are ignored
  assign mode_wr = wr & (bus.addr == REG_MODE) & (bus.wdata <= DATA_W'(1));

  // ====================
  // Registers
  // ====================

  always_ff @(posedge clk_i) begin
    if (rst_i | soft_reset) begin
      led_val <= '0;
    end else if (val_wr) begin
      led_val <= bus.wdata[LED_W-1:0];
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i | soft_reset) begin
      led_mode <= 1'b0;
    end else if (mode_wr) begin
      led_mode <= bus.wdata[0];
    end
  end

  // ====================
  // Blink counter
  // ====================

  // One full period is lit half plus dark half
  assign cntr_wrap = cntr == 32'(2 * BLINK_HALF - 1);

  always_ff @(posedge clk_i) begin
    if (rst_i | soft_reset) begin
      cntr <= '0;
    end else if (!led_mode || cntr_wrap) begin
      cntr <= '0;
    end else begin
      cntr <= cntr + 32'd1;
    end
  end

  // Held at zero in steady mode, so the value shows constantly
  assign led_o = (cntr < BLINK_HALF) ? led_val : '0;

  // ====================
  // Read data
  // ====================

  always_ff @(posedge clk_i) begin
    if (rst_i | soft_reset) begin
      bus.rdata <= '0;
    end else if (rd) begin
      case (bus.addr)
        REG_VALUE: bus.rdata <= {{(DATA_W-LED_W){1'b0}}, led_val};
        REG_MODE:  bus.rdata <= {{(DATA_W-1){1'b0}}, led_mode};
        // Unknown offsets keep the last read value
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: sw_ctrl/sw_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module sw_ctrl (
  input  logic                        clk_i,
  input  logic                        rst_i,

  periph_bus_if.device                bus,

  input  logic [periph_pkg::SW_W-1:0] sw_i,
  output logic                        irq_o
);
  import periph_pkg::*;

  logic [SW_W-1:0] sw_meta;
  logic [SW_W-1:0] sw_sync;
  logic [SW_W-1:0] sw_prev;
  logic            changed;
  logic            irq_en;

  logic            wr;
  logic            rd;
  logic            soft_reset;
  logic            sw_diff;

  assign wr = bus.req & bus.we;
  assign rd = bus.req & ~bus.we;

  assign soft_reset = wr & (bus.addr == REG_RESET) & (bus.wdata == DATA_W'(1));

  // ====================
  // Synchronizer
  // ====================

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      sw_meta <= '0;
      sw_sync <= '0;
      sw_prev <= '0;
    end else begin
      sw_meta <= sw_i;
      sw_sync <= sw_meta;
      sw_prev <= sw_sync;
    end
  end

  assign sw_diff = sw_sync != sw_prev;

  // ====================
  // Flag and interrupt
  // ====================

  // A new change wins over a clear in the same cycle
  always_ff @(posedge clk_i) begin
    if (rst_i | soft_reset) begin
      changed <= 1'b0;
    end else if (sw_diff) begin
      changed <= 1'b1;
    end else if (wr && bus.addr == REG_CHANGED && bus.wdata == DATA_W'(1)) begin
      changed <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i | soft_reset) begin
      irq_en <= 1'b0;
    end else if (wr && bus.addr == REG_IRQ_EN) begin
      irq_en <= bus.wdata[0];
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i | soft_reset) begin
      irq_o <= 1'b0;
    end else begin
      irq_o <= changed & irq_en;
    end
  end

  // ====================
  // Read data
  // ====================

  always_ff @(posedge clk_i) begin
    if (rst_i | soft_reset) begin
      bus.rdata <= '0;
    end else if (rd) begin
      case (bus.addr)
        REG_VALUE:   bus.rdata <= {{(DATA_W-SW_W){1'b0}}, sw_sync};
        REG_IRQ_EN:  bus.rdata <= {{(DATA_W-1){1'b0}}, irq_en};
        REG_CHANGED: bus.rdata <= {{(DATA_W-1){1'b0}}, changed};
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: rtl/wb_periph_bridge.sv
`timescale 1ns/1ps
`default_nettype none

module wb_periph_bridge (
  input  logic                          clk_i,
  input  logic                          rst_i,

  input  logic                          wb_cyc_i,
  input  logic                          wb_stb_i,
  input  logic                          wb_we_i,
  input  logic [periph_pkg::ADDR_W-1:0] wb_adr_i,
  input  logic [periph_pkg::DATA_W-1:0] wb_dat_i,
  output logic [periph_pkg::DATA_W-1:0] wb_dat_o,
  output logic                          wb_ack_o,

  periph_bus_if.host                    led_bus,
  periph_bus_if.host                    sw_bus
);
  import periph_pkg::*;

  logic              ack_pending;
  logic              start;
  logic              hit_led;
  logic              hit_sw;
  logic [ADDR_W-1:0] offset;
  sel_e              sel_d;
  sel_e              sel_q;

  // ====================
  // Decode
  // ====================

  // Master keeps stb up through the ack cycle, so mask it there
  assign start = wb_cyc_i & wb_stb_i & ~ack_pending;

  assign hit_led = wb_adr_i[ADDR_W-1:OFFS_W] == LED_BASE[ADDR_W-1:OFFS_W];
  assign hit_sw  = wb_adr_i[ADDR_W-1:OFFS_W] == SW_BASE[ADDR_W-1:OFFS_W];

  assign offset = {{(ADDR_W-OFFS_W){1'b0}}, wb_adr_i[OFFS_W-1:0]};

  always_comb begin
    if (hit_led) begin
      sel_d = SEL_LED;
    end else if (hit_sw) begin
      sel_d = SEL_SW;
    end else begin
      sel_d = SEL_NONE;
    end
  end

  // ====================
  // Device requests
  // ====================

  assign led_bus.req   = start & hit_led;
  assign led_bus.we    = wb_we_i;
  assign led_bus.addr  = offset;
  assign led_bus.wdata = wb_dat_i;

  assign sw_bus.req    = start & hit_sw;
  assign sw_bus.we     = wb_we_i;
  assign sw_bus.addr   = offset;
  assign sw_bus.wdata  = wb_dat_i;

  // ====================
  // Acknowledge
  // ====================

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ack_pending <= 1'b0;
      sel_q       <= SEL_NONE;
    end else begin
      ack_pending <= start;
      if (start) begin
        sel_q <= sel_d;
      end
    end
  end

  assign wb_ack_o = ack_pending;

  // Device rdata is registered on the same edge as ack
  always_comb begin
    case (sel_q)
      SEL_LED: wb_dat_o = led_bus.rdata;
      SEL_SW:  wb_dat_o = sw_bus.rdata;
      default: wb_dat_o = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: rtl/periph_top.sv
`timescale 1ns/1ps
`default_nettype none

module periph_top #(
  parameter int unsigned BLINK_HALF = periph_pkg::BLINK_HALF_DEFAULT
) (
  input  logic                          clk_i,
  input  logic                          rst_i,

  // Wishbone classic slave
  input  logic                          wb_cyc_i,
  input  logic                          wb_stb_i,
  input  logic                          wb_we_i,
  input  logic [periph_pkg::ADDR_W-1:0] wb_adr_i,
  input  logic [periph_pkg::DATA_W-1:0] wb_dat_i,
  output logic [periph_pkg::DATA_W-1:0] wb_dat_o,
  output logic                          wb_ack_o,

  // Board side
  input  logic [periph_pkg::SW_W-1:0]   sw_i,
  output logic [periph_pkg::LED_W-1:0]  led_o,
  output logic                          irq_o
);

  periph_bus_if led_bus ();
  periph_bus_if sw_bus ();

  // ====================
  // Bus bridge
  // ====================

  wb_periph_bridge i_bridge (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .wb_cyc_i (wb_cyc_i),
    .wb_stb_i (wb_stb_i),
    .wb_we_i  (wb_we_i),
    .wb_adr_i (wb_adr_i),
    .wb_dat_i (wb_dat_i),
    .wb_dat_o (wb_dat_o),
    .wb_ack_o (wb_ack_o),
    .led_bus  (led_bus.host),
    .sw_bus   (sw_bus.host)
  );

  // ====================
  // Peripherals
  // ====================

  led_ctrl #(
    .BLINK_HALF (BLINK_HALF)
  ) i_led_ctrl (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .bus   (led_bus.device),
    .led_o (led_o)
  );

  sw_ctrl i_sw_ctrl (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .bus   (sw_bus.device),
    .sw_i  (sw_i),
    .irq_o (irq_o)
  );

endmodule

`default_nettype wire

// File: verif/periph_sva.sv
`timescale 1ns/1ps
`default_nettype none

module periph_sva (
  input logic clk_i,
  input logic rst_i,
  input logic wb_cyc_i,
  input logic wb_stb_i,
  input logic wb_ack_i,
  input logic led_req_i,
  input logic sw_req_i
);

  // ====================
  // Wishbone handshake
  // ====================

  ack_single_cycle: assert property (@(posedge clk_i) disable iff (rst_i)
    wb_ack_i |=> !wb_ack_i)
    else $error("ack stayed high for more than one cycle");

  ack_after_stb: assert property (@(posedge clk_i) disable iff (rst_i)
    (wb_cyc_i && wb_stb_i && !wb_ack_i) |=> wb_ack_i)
    else $error("ack did not follow stb by one cycle");

  // ====================
  // Device requests
  // ====================

  req_one_hot: assert property (@(posedge clk_i) disable iff (rst_i)
    !(led_req_i && sw_req_i))
    else $error("both device requests high");

  no_req_in_ack: assert property (@(posedge clk_i) disable iff (rst_i)
    wb_ack_i |-> !(led_req_i || sw_req_i))
    else $error("device request issued during ack");

endmodule

bind wb_periph_bridge periph_sva i_periph_sva (
  .clk_i     (clk_i),
  .rst_i     (rst_i),
  .wb_cyc_i  (wb_cyc_i),
  .wb_stb_i  (wb_stb_i),
  .wb_ack_i  (wb_ack_o),
  .led_req_i (led_bus.req),
  .sw_req_i  (sw_bus.req)
);

`default_nettype wire

// File: verif/periph_tb.sv
`timescale 1ns/1ps
`default_nettype none

module periph_tb;
  import periph_pkg::*;

  localparam int MAX_CASES = 64;
  localparam int ACK_WAIT  = 8;

  logic              clk_i = 1'b0;
  logic              rst_i;
  logic              wb_cyc_i;
  logic              wb_stb_i;
  logic              wb_we_i;
  logic [ADDR_W-1:0] wb_adr_i;
  logic [DATA_W-1:0] wb_dat_i;
  logic [DATA_W-1:0] wb_dat_o;
  logic              wb_ack_o;
  logic [SW_W-1:0]   sw_i;
  logic [LED_W-1:0]  led_o;
  logic              irq_o;

  // Four words per line of the case file
  logic [31:0]     cases [4*MAX_CASES];
  logic [31:0]     rng         = 32'd55;
  logic [SW_W-1:0] sw_last     = '0;
  int              cycle_cnt   = 0;
  int              cycle_limit = 0;
  int              checks      = 0;
  int              errors      = 0;

  always #50 clk_i = ~clk_i;

  periph_top #(
    .BLINK_HALF (8)
  ) i_periph_top (.*);

  // ====================
  // Helpers
  // ====================

  function automatic logic [31:0] next_random(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("error at %0t ns: %s: got %h, expected %h", $time, what, actual, expected);
    end
  endtask

  // One Wishbone classic access, held until ack
  task automatic bus_access(input logic we, input logic [31:0] adr, input logic [31:0] dat,
                            output logic [31:0] rdat);
    int waited;
    waited = 0;
    rdat   = '0;
    @(posedge clk_i);
    wb_cyc_i <= 1'b1;
    wb_stb_i <= 1'b1;
    wb_we_i  <= we;
    wb_adr_i <= adr;
    wb_dat_i <= dat;
    do begin
      @(negedge clk_i);
      waited++;
    end while (!wb_ack_o && waited < ACK_WAIT);
    if (wb_ack_o) begin
      rdat = wb_dat_o;
    end else begin
      errors++;
      $display("No acknowledge came for the access to address %h", adr);
    end
    @(posedge clk_i);
    wb_cyc_i <= 1'b0;
    wb_stb_i <= 1'b0;
    wb_we_i  <= 1'b0;
  endtask

  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("Timeout: the cases did not finish within %0d cycles", cycle_limit);
      $display("Errors found");
      $finish;
    end
  end

  // ====================
  // Case runner
  // ====================

  initial begin
    int              i;
    int              test_id;
    int              test_checks;
    int              test_errors;
    int              tests;
    logic [7:0]      op;
    logic [31:0]     adr;
    logic [31:0]     dat;
    logic [31:0]     exp_val;
    logic [31:0]     rdat;
    logic [SW_W-1:0] pattern;

    rst_i    = 1'b1;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i  = 1'b0;
    wb_adr_i = '0;
    wb_dat_i = '0;
    sw_i     = '0;
    $readmemh("verif/periph_cases.txt", cases);

    // Reset, margin, then three cycles per access and the length of each wait
    cycle_limit = 3 + 40;
    for (i = 0; i < MAX_CASES && cases[4*i] !== 32'hF0; i++) begin
      case (cases[4*i][3:0])
        4'h1, 4'h2: cycle_limit += 3;
        4'h4:       cycle_limit += cases[4*i+2];
        default:    cycle_limit += 1;
      endcase
    end

    repeat (3) @(posedge clk_i);
    rst_i <= 1'b0;

    test_id     = 0;
    tests       = 0;
    test_checks = 0;
    test_errors = 0;
    for (i = 0; i < MAX_CASES; i++) begin
      op      = cases[4*i][7:0];
      adr     = cases[4*i+1];
      dat     = cases[4*i+2];
      exp_val = cases[4*i+3];
      if ($isunknown(op)) begin
        errors++;
        $display("The case file ended without its end marker");
        break;
      end
      // Upper digit is the test number
      if (op[7:4] != test_id) begin
        if (test_id != 0) begin
          tests++;
          $display("test %0d: %0d checks, %0d mismatches", test_id,
                   checks - test_checks, errors - test_errors);
        end
        test_id     = op[7:4];
        test_checks = checks;
        test_errors = errors;
      end
      if (op == 8'hF0) begin
        break;
      end
      case (op[3:0])
        4'h1: bus_access(1'b1, adr, dat, rdat);
        4'h2: begin
          bus_access(1'b0, adr, '0, rdat);
          // Waits of two edges or more let the synchronizer pass the pattern
          if (dat == 32'd1) begin
            exp_val = {{(DATA_W-SW_W){1'b0}}, sw_last};
          end
          check_value(rdat, exp_val, $sformatf("read of %h", adr));
        end
        4'h3: begin
          pattern = dat[SW_W-1:0];
          if (exp_val == 32'd1) begin
            rng     = next_random(rng);
            pattern = rng[SW_W-1:0];
            // Same pattern again would flag no change
            if (pattern == sw_last) begin
              pattern = ~pattern;
            end
          end
          sw_last = pattern;
          @(posedge clk_i);
          sw_i <= pattern;
        end
        4'h4: repeat (dat) @(posedge clk_i);
        4'h5: begin
          @(negedge clk_i);
          check_value({{(DATA_W-LED_W){1'b0}}, led_o}, exp_val, "LED output");
        end
        4'h6: begin
          @(negedge clk_i);
          check_value({{(DATA_W-1){1'b0}}, irq_o}, exp_val, "IRQ output");
        end
        default: begin
          errors++;
          $display("Unknown operation %h on line %0d of the case file", op, i);
        end
      endcase
    end

    $display("tests: %0d, checks: %0d, mismatches: %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verif/periph_cases.txt
// Columns in hex: test and op, address, data, expected. Ops 1 write, 2 read, 3 switches,
// 4 wait, 5 LED, 6 IRQ, F0 end. Data 1 on a read or expected 1 on op 3 is a random pattern.
11 00001000 0000A5C3 00000000
15 00000000 00000000 0000A5C3
12 00001000 00000000 0000A5C3
11 00001000 00010001 00000000
12 00001000 00000000 0000A5C3
21 00001004 00000001 00000000
25 00000000 00000000 0000A5C3
24 00000000 00000006 00000000
25 00000000 00000000 0000A5C3
24 00000000 00000001 00000000
25 00000000 00000000 00000000
21 00001004 00000002 00000000
22 00001004 00000000 00000001
21 00001004 00000000 00000000
25 00000000 00000000 0000A5C3
31 00001004 00000001 00000000
31 00001024 00000002 00000000
32 00001000 00000000 0000A5C3
31 00001024 00000001 00000000
32 00001000 00000000 00000000
32 00001004 00000000 00000000
35 00000000 00000000 00000000
43 00000000 00000000 00000001
44 00000000 00000004 00000000
42 00002000 00000001 00000000
42 0000200C 00000000 00000001
46 00000000 00000000 00000000
41 00002008 00000001 00000000
46 00000000 00000000 00000001
41 0000200C 00000001 00000000
46 00000000 00000000 00000000
52 00003000 00000000 00000000
51 00001100 0000FFFF 00000000
52 00001000 00000000 00000000
52 00002008 00000000 00000001
F0 00000000 00000000 00000000

// File: project.f
common/periph_pkg.sv
common/periph_bus_if.sv
led_ctrl/led_ctrl.sv
sw_ctrl/sw_ctrl.sv
rtl/wb_periph_bridge.sv
rtl/periph_top.sv
verif/periph_sva.sv
verif/periph_tb.sv

// File: Bender.yml
package:
  name: periph_subsystem

sources:
  - common/periph_pkg.sv
  - common/periph_bus_if.sv
  - led_ctrl/led_ctrl.sv
  - sw_ctrl/sw_ctrl.sv
  - rtl/wb_periph_bridge.sv
  - rtl/periph_top.sv
  - target: test
    files:
      - verif/periph_sva.sv
      - verif/periph_tb.sv
